// File: design/sw_alloc_defines.svh
`ifndef SW_ALLOC_DEFINES_SVH
`define SW_ALLOC_DEFINES_SVH

// Buffer geometry.
`define SW_NUM_SRAMS      32    // Shared SRAM blocks.
`define SW_SRAM_CAPACITY  1024  // Half-words per block.

// ------------------------------
// Host register map, word addresses.
`define SW_WB_ADR_W       8
`define SW_REG_CTRL       0     // Mode, threshold, viscous.
`define SW_REG_REQ        1     // Post a packet write request.
`define SW_REG_MASK       2     // Accessible blocks, one bit each.
`define SW_REG_RELEASE    3     // Return drained space.
`define SW_REG_RESULT     4     // Last allocation, read clears valid.
`define SW_REG_FREE_BASE  32    // Free space of block n at 32+n.

`endif

// File: design/sw_alloc_pkg.sv
package sw_alloc_pkg;

    typedef logic [4:0]  sram_idx_t;     // Block number.
    typedef logic [3:0]  port_idx_t;     // Switch port number.
    typedef logic [8:0]  pkt_len_t;      // Packet length in half-words.
    typedef logic [10:0] free_space_t;   // Free half-words, holds the full capacity.
    typedef logic [8:0]  pkt_amount_t;   // Packets for one destination in one block.

    typedef struct packed {
        logic [1:0] mode;                // Scan order select.
        logic [4:0] threshold;           // Scan ticks before a match may end.
        logic       viscous;             // Reuse the previous block when it fits.
    } alloc_cfg_t;

    typedef struct packed {
        port_idx_t dest;                 // Destination port.
        pkt_len_t  length;               // Space to reserve.
    } alloc_req_t;

    typedef struct packed {
        logic        accessible;         // Mask bit of the block.
        free_space_t free_space;
        pkt_amount_t packet_amount;      // Count for the looked-up destination.
    } sram_status_t;

    // Commit takes space and adds a packet, release does the reverse.
    typedef struct packed {
        logic      valid;
        sram_idx_t sram;
        port_idx_t dest;
        pkt_len_t  length;
    } sram_update_t;

    typedef enum logic [1:0] {
        IDLE,
        MATCHING,
        DONE
    } match_state_t;

endpackage

// File: design/wb_req_intake.sv
`timescale 1ns/1ps
`include "sw_alloc_defines.svh"

module wb_req_intake (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cyc,
    input  logic                          stb,
    input  logic                          we,
    input  logic [`SW_WB_ADR_W-1:0]       adr,
    input  logic [31:0]                   dat_w,
    input  logic                          match_end,
    output sw_alloc_pkg::alloc_cfg_t      cfg,
    output logic [`SW_NUM_SRAMS-1:0]      mask,
    output sw_alloc_pkg::alloc_req_t      req,
    output logic                          match_enable,
    output sw_alloc_pkg::sram_update_t    release_upd,
    output logic                          wr_ack
);

    logic bus_wr;    // New write strobe, not yet acked.
    logic req_take;  // REQ write accepted this cycle.

    assign bus_wr   = cyc && stb && we && !wr_ack;
    assign req_take = bus_wr && !match_enable && (adr == `SW_WB_ADR_W'(`SW_REG_REQ));

    // ------------------------------
    // Register writes and write ack.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg          <= '0;             // Mode 0, no sticky.
            mask         <= '1;             // All blocks accessible.
            release_upd  <= '0;
            match_enable <= 1'b0;
            wr_ack       <= 1'b0;
        end else begin
            wr_ack            <= 1'b0;      // Single-cycle pulse.
            release_upd.valid <= 1'b0;
            if (match_end) begin
                match_enable <= 1'b0;      // Matcher goes idle next.
            end
            if (bus_wr) begin
                case (adr)
                    `SW_WB_ADR_W'(`SW_REG_CTRL): begin
                        cfg.mode      <= dat_w[1:0];
                        cfg.threshold <= dat_w[12:8];
                        cfg.viscous   <= dat_w[16];
                        wr_ack        <= 1'b1;
                    end
                    `SW_WB_ADR_W'(`SW_REG_MASK): begin
                        mask   <= dat_w;
                        wr_ack <= 1'b1;
                    end
                    `SW_WB_ADR_W'(`SW_REG_RELEASE): begin
                        release_upd <= '{valid: 1'b1, sram: dat_w[4:0],
                                         dest: dat_w[11:8], length: dat_w[24:16]};
                        wr_ack      <= 1'b1;
                    end
                    `SW_WB_ADR_W'(`SW_REG_REQ): begin
                        if (!match_enable) begin   // Stall ack while a match runs.
                            match_enable <= 1'b1;
                            wr_ack       <= 1'b1;
                        end
                    end
                    default: wr_ack <= 1'b1;      // Read-only or unmapped, just ack.
                endcase
            end
        end
    end

    // Request payload, dest in 3:0 and length in 24:16.
    always_ff @(posedge clk) begin
        if (req_take) begin
            req.dest   <= dat_w[3:0];
            req.length <= dat_w[24:16];
        end
    end

endmodule

// File: design/port_wr_sram_matcher.sv
`timescale 1ns/1ps

module port_wr_sram_matcher #(
    parameter int PORT_IDX = 0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  sw_alloc_pkg::alloc_cfg_t      cfg,
    input  sw_alloc_pkg::alloc_req_t      req,
    input  logic                          match_enable,
    input  sw_alloc_pkg::sram_status_t    status,
    output logic                          match_end,
    output sw_alloc_pkg::sram_idx_t       matching_next_sram,
    output sw_alloc_pkg::sram_idx_t       matching_best_sram
);

    localparam sw_alloc_pkg::sram_idx_t OWN_PAIR_LO = sw_alloc_pkg::sram_idx_t'(2 * PORT_IDX);
    localparam sw_alloc_pkg::sram_idx_t OWN_PAIR_HI = OWN_PAIR_LO | 5'd1;
    localparam sw_alloc_pkg::sram_idx_t OWN_BLOCK   = sw_alloc_pkg::sram_idx_t'(PORT_IDX);

    sw_alloc_pkg::match_state_t state;
    sw_alloc_pkg::sram_idx_t    matching_sram;   // Block that status describes.
    logic [4:0]                 tick;            // Scan cycles in this match.
    logic                       found;           // A candidate is held.
    sw_alloc_pkg::pkt_amount_t  best_amount;
    sw_alloc_pkg::free_space_t  best_free;
    logic                       prev_valid;      // A normal match has completed.
    sw_alloc_pkg::port_idx_t    prev_dest;
    sw_alloc_pkg::free_space_t  prev_free;       // Space left in the previous block.
    logic                       cand;
    logic                       done_now;
    logic                       sticky;

    // ------------------------------
    // Scan order, one block per cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            matching_next_sram <= OWN_PAIR_LO;
        end else begin
            case (cfg.mode)
                2'd0: matching_next_sram <= (matching_next_sram == OWN_PAIR_LO) ?
                                            OWN_PAIR_HI : OWN_PAIR_LO;
                2'd1: begin                                 // Own block, then 16 to 31.
                    if (!matching_next_sram[4]) begin
                        matching_next_sram <= 5'd16;
                    end else if (matching_next_sram == 5'd31) begin
                        matching_next_sram <= OWN_BLOCK;
                    end else begin
                        matching_next_sram <= matching_next_sram + 5'd1;
                    end
                end
                default: matching_next_sram <= matching_next_sram + 5'd1;  // Wraps at 31.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        matching_sram <= matching_next_sram;   // Lines up with the table lookup.
    end

    // ------------------------------
    // Candidate search.
    assign cand = (state == sw_alloc_pkg::MATCHING) && status.accessible &&
                  (status.free_space >= sw_alloc_pkg::free_space_t'(req.length)) &&
                  (status.packet_amount >= best_amount);
    assign done_now = (state == sw_alloc_pkg::MATCHING) && found && (tick >= cfg.threshold);
    assign sticky   = cfg.viscous && prev_valid && (req.dest == prev_dest) &&
                      (prev_free >= sw_alloc_pkg::free_space_t'(req.length));

    always_ff @(posedge clk) begin
        if (cand && !done_now) begin          // Best is frozen once the match ends.
            matching_best_sram <= matching_sram;
            best_free          <= status.free_space;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= sw_alloc_pkg::IDLE;
            match_end   <= 1'b0;
            tick        <= '0;
            found       <= 1'b0;
            best_amount <= '0;
            prev_valid  <= 1'b0;
            prev_dest   <= '0;
            prev_free   <= '0;
        end else begin
            match_end <= 1'b0;
            case (state)
                sw_alloc_pkg::IDLE: begin
                    if (match_enable && sticky) begin     // Keep the previous block.
                        prev_free <= prev_free - sw_alloc_pkg::free_space_t'(req.length);
                        match_end <= 1'b1;
                        state     <= sw_alloc_pkg::DONE;
                    end else if (match_enable) begin
                        tick        <= '0;
                        found       <= 1'b0;
                        best_amount <= '0;
                        state       <= sw_alloc_pkg::MATCHING;
                    end
                end
                sw_alloc_pkg::MATCHING: begin
                    if (tick != 5'd31) begin
                        tick <= tick + 5'd1;            // Saturates.
                    end
                    if (done_now) begin
                        match_end  <= 1'b1;
                        prev_valid <= 1'b1;
                        prev_dest  <= req.dest;
                        prev_free  <= best_free - sw_alloc_pkg::free_space_t'(req.length);
                        state      <= sw_alloc_pkg::DONE;
                    end else if (cand) begin
                        found       <= 1'b1;
                        best_amount <= status.packet_amount;
                    end
                end
                default: state <= sw_alloc_pkg::IDLE;   // DONE lasts one cycle.
            endcase
        end
    end

endmodule

// File: design/sram_status_table.sv
`timescale 1ns/1ps
`include "sw_alloc_defines.svh"

module sram_status_table (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`SW_NUM_SRAMS-1:0]      mask,
    input  sw_alloc_pkg::sram_idx_t       lookup_sram,
    input  sw_alloc_pkg::port_idx_t       lookup_dest,
    input  sw_alloc_pkg::sram_update_t    commit,
    input  sw_alloc_pkg::sram_update_t    release_upd,
    input  sw_alloc_pkg::sram_idx_t       free_rd_sram,
    output sw_alloc_pkg::sram_status_t    status,
    output sw_alloc_pkg::free_space_t     free_rd
);

    localparam int NUM_PORTS = 2 ** $bits(sw_alloc_pkg::port_idx_t);

    sw_alloc_pkg::free_space_t free_space [`SW_NUM_SRAMS];
    sw_alloc_pkg::pkt_amount_t pkt_cnt    [`SW_NUM_SRAMS][NUM_PORTS];

    // ------------------------------
    // Commit and release, both land when they hit one block.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < `SW_NUM_SRAMS; b++) begin
                free_space[b] <= sw_alloc_pkg::free_space_t'(`SW_SRAM_CAPACITY);
                for (int d = 0; d < NUM_PORTS; d++) begin
                    pkt_cnt[b][d] <= '0;
                end
            end
        end else begin
            for (int b = 0; b < `SW_NUM_SRAMS; b++) begin
                free_space[b] <= free_space[b]
                    - ((commit.valid && commit.sram == b) ?
                       sw_alloc_pkg::free_space_t'(commit.length) : '0)
                    + ((release_upd.valid && release_upd.sram == b) ?
                       sw_alloc_pkg::free_space_t'(release_upd.length) : '0);
                for (int d = 0; d < NUM_PORTS; d++) begin
                    pkt_cnt[b][d] <= pkt_cnt[b][d]
                        + sw_alloc_pkg::pkt_amount_t'(commit.valid && commit.sram == b &&
                                                      commit.dest == d)
                        - sw_alloc_pkg::pkt_amount_t'(release_upd.valid &&
                                                      release_upd.sram == b &&
                                                      release_upd.dest == d);
                end
            end
        end
    end

    // Registered lookup for the matcher, one cycle behind the address.
    always_ff @(posedge clk) begin
        status.accessible    <= mask[lookup_sram];
        status.free_space    <= free_space[lookup_sram];
        status.packet_amount <= pkt_cnt[lookup_sram][lookup_dest];
    end

    assign free_rd = free_space[free_rd_sram];   // Bus read path.

endmodule

// File: design/alloc_result_readback.sv
`timescale 1ns/1ps
`include "sw_alloc_defines.svh"

module alloc_result_readback (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cyc,
    input  logic                          stb,
    input  logic                          we,
    input  logic [`SW_WB_ADR_W-1:0]       adr,
    input  logic                          wr_ack,
    input  logic                          match_end,
    input  sw_alloc_pkg::sram_idx_t       matching_best_sram,
    input  sw_alloc_pkg::alloc_req_t      req,
    input  sw_alloc_pkg::alloc_cfg_t      cfg,
    input  sw_alloc_pkg::free_space_t     free_rd,
    output sw_alloc_pkg::sram_update_t    commit,
    output sw_alloc_pkg::sram_idx_t       free_rd_sram,
    output logic [31:0]                   dat_r,
    output logic                          ack
);

    logic                     rd_start;      // New read strobe.
    logic                     rd_ack;
    logic                     result_valid;
    sw_alloc_pkg::sram_idx_t  result_sram;
    logic [`SW_WB_ADR_W-1:0]  free_off;      // Offset into the free-space window.
    logic                     free_hit;

    assign rd_start     = cyc && stb && !we && !rd_ack;
    assign free_off     = adr - `SW_WB_ADR_W'(`SW_REG_FREE_BASE);
    assign free_hit     = free_off < `SW_WB_ADR_W'(`SW_NUM_SRAMS);
    assign free_rd_sram = free_off[4:0];
    assign ack          = rd_ack || wr_ack;  // One ack line for the bus.

    // ------------------------------
    // Result capture and commit pulse.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit       <= '0;
            result_valid <= 1'b0;
            rd_ack       <= 1'b0;
        end else begin
            rd_ack       <= rd_start;
            commit.valid <= 1'b0;
            if (rd_start && adr == `SW_WB_ADR_W'(`SW_REG_RESULT)) begin
                result_valid <= 1'b0;           // Cleared by the read.
            end
            if (match_end) begin                // New result wins over a clear.
                result_valid <= 1'b1;
                commit       <= '{valid: 1'b1, sram: matching_best_sram,
                                  dest: req.dest, length: req.length};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (match_end) begin
            result_sram <= matching_best_sram;
        end
    end

    // Read data, valid in the ack cycle.
    always_ff @(posedge clk) begin
        if (rd_start) begin
            if (free_hit) begin
                dat_r <= {21'd0, free_rd};
            end else if (adr == `SW_WB_ADR_W'(`SW_REG_CTRL)) begin
                dat_r <= {15'd0, cfg.viscous, 3'd0, cfg.threshold, 6'd0, cfg.mode};
            end else if (adr == `SW_WB_ADR_W'(`SW_REG_RESULT)) begin
                dat_r <= {result_valid, 26'd0, result_sram};
            end else begin
                dat_r <= '0;
            end
        end
    end

endmodule

// File: design/sw_alloc_top.sv
`timescale 1ns/1ps
`include "sw_alloc_defines.svh"

module sw_alloc_top #(
    parameter int PORT_IDX = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [`SW_WB_ADR_W-1:0]  adr,
    input  logic [31:0]              dat_w,
    output logic [31:0]              dat_r,
    output logic                     ack
);

    sw_alloc_pkg::alloc_cfg_t        cfg;
    logic [`SW_NUM_SRAMS-1:0]        mask;
    sw_alloc_pkg::alloc_req_t        req;
    logic                            match_enable;
    logic                            match_end;
    logic                            wr_ack;
    sw_alloc_pkg::sram_update_t      release_upd;
    sw_alloc_pkg::sram_update_t      commit;
    sw_alloc_pkg::sram_idx_t         matching_next_sram;
    sw_alloc_pkg::sram_idx_t         matching_best_sram;
    sw_alloc_pkg::sram_status_t      status;
    sw_alloc_pkg::sram_idx_t         free_rd_sram;
    sw_alloc_pkg::free_space_t       free_rd;

    wb_req_intake u_wb_req_intake (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .match_end(match_end), .cfg(cfg), .mask(mask), .req(req),
        .match_enable(match_enable), .release_upd(release_upd), .wr_ack(wr_ack)
    );

    port_wr_sram_matcher #(.PORT_IDX(PORT_IDX)) u_port_wr_sram_matcher (
        .clk(clk), .rst_n(rst_n), .cfg(cfg), .req(req), .match_enable(match_enable),
        .status(status), .match_end(match_end),
        .matching_next_sram(matching_next_sram), .matching_best_sram(matching_best_sram)
    );

    sram_status_table u_sram_status_table (
        .clk(clk), .rst_n(rst_n), .mask(mask), .lookup_sram(matching_next_sram),
        .lookup_dest(req.dest), .commit(commit), .release_upd(release_upd),
        .free_rd_sram(free_rd_sram), .status(status), .free_rd(free_rd)
    );

    alloc_result_readback u_alloc_result_readback (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .wr_ack(wr_ack), .match_end(match_end), .matching_best_sram(matching_best_sram),
        .req(req), .cfg(cfg), .free_rd(free_rd), .commit(commit),
        .free_rd_sram(free_rd_sram), .dat_r(dat_r), .ack(ack)
    );

endmodule

// File: sim/alloc_checker.sv
`timescale 1ns/1ps
`include "sw_alloc_defines.svh"

module alloc_checker #(
    parameter int PORT_IDX = 0
) (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          cyc,
    input logic                          stb,
    input logic                          we,
    input logic [`SW_WB_ADR_W-1:0]       adr,
    input logic [31:0]                   dat_w,
    input logic [31:0]                   dat_r,
    input logic                          ack,
    input sw_alloc_pkg::sram_update_t    commit
);

    int errors      = 0;
    int commits     = 0;                        // Results seen on the commit path.
    int req_acks    = 0;
    int sticky_hits = 0;
    int since_ack   = 1000;                     // Cycles since the last REQ ack.

    sw_alloc_pkg::free_space_t model_free [`SW_NUM_SRAMS];
    sw_alloc_pkg::pkt_amount_t model_cnt  [`SW_NUM_SRAMS][16];
    logic [31:0]               model_mask;
    logic [1:0]                mode;
    logic [4:0]                thr;
    logic                      visc;
    sw_alloc_pkg::alloc_req_t  pend;            // Request now being matched.
    logic                      pend_sticky;     // Previous block must be reused.
    logic                      prev_valid;
    sw_alloc_pkg::port_idx_t   prev_dest;
    sw_alloc_pkg::sram_idx_t   prev_blk;
    sw_alloc_pkg::free_space_t prev_free;       // Room left in the previous block.
    sw_alloc_pkg::sram_idx_t   last_blk;        // Block RESULT should show.

    // ------------------------------
    // Reference model.
    function automatic int scan_cycle(input logic [1:0] m);
        if (m == 2'd0) return 2;                // Own pair.
        if (m == 2'd1) return 17;               // Own block plus 16 to 31.
        return 32;
    endfunction

    // Eligible blocks for a request and the top count among them.
    function automatic logic [31:0] eligible_blocks(input logic [1:0] m,
                                                    input sw_alloc_pkg::alloc_req_t r,
                                                    output sw_alloc_pkg::pkt_amount_t best);
        logic [31:0] elig;
        logic        in_scan;
        elig = '0;
        best = '0;
        for (int b = 0; b < `SW_NUM_SRAMS; b++) begin
            case (m)
                2'd0:    in_scan = (b / 2 == PORT_IDX);
                2'd1:    in_scan = (b == PORT_IDX) || (b >= 16);
                default: in_scan = 1'b1;
            endcase
            if (in_scan && model_mask[b] &&
                model_free[b] >= sw_alloc_pkg::free_space_t'(r.length)) begin
                elig[b] = 1'b1;
                if (model_cnt[b][r.dest] > best) best = model_cnt[b][r.dest];
            end
        end
        return elig;
    endfunction

    task automatic reset_model();
        for (int b = 0; b < `SW_NUM_SRAMS; b++) begin
            model_free[b] = sw_alloc_pkg::free_space_t'(`SW_SRAM_CAPACITY);
            for (int d = 0; d < 16; d++) model_cnt[b][d] = '0;
        end
        model_mask  = '1;
        mode        = 2'd0;
        thr         = 5'd0;
        visc        = 1'b0;
        pend        = '0;
        pend_sticky = 1'b0;
        prev_valid  = 1'b0;
        prev_dest   = '0;
        prev_blk    = '0;
        prev_free   = '0;
        last_blk    = '0;
    endtask

    // ------------------------------
    // Bus writes update the model.
    task automatic track_write();
        case (int'(adr))
            `SW_REG_CTRL: begin
                mode = dat_w[1:0];
                thr  = dat_w[12:8];
                visc = dat_w[16];
            end
            `SW_REG_MASK: model_mask = dat_w;
            `SW_REG_RELEASE: begin
                model_free[dat_w[4:0]] += sw_alloc_pkg::free_space_t'(dat_w[24:16]);
                model_cnt[dat_w[4:0]][dat_w[11:8]] -= 9'd1;
            end
            `SW_REG_REQ: begin
                if (commits != req_acks) begin        // Back-pressure must hold the ack.
                    errors++;
                    $display("REQ acked while an earlier request still had no result.");
                end
                pend.dest   = dat_w[3:0];
                pend.length = dat_w[24:16];
                pend_sticky = visc && prev_valid && (pend.dest == prev_dest) &&
                              (prev_free >= sw_alloc_pkg::free_space_t'(pend.length));
                since_ack   = 0;
                req_acks++;
            end
            default: ;
        endcase
    endtask

    task automatic check_read();
        int          off;
        logic [31:0] ctrl_exp;
        off      = int'(adr) - `SW_REG_FREE_BASE;
        ctrl_exp = '0;
        ctrl_exp[1:0]  = mode;                  // Same layout as the CTRL write.
        ctrl_exp[12:8] = thr;
        ctrl_exp[16]   = visc;
        if (off >= 0 && off < `SW_NUM_SRAMS) begin
            if (dat_r != 32'(model_free[off])) begin
                errors++;
                $display("[FAIL] dat_r (free of block %0d) exp 0x%h got 0x%h",
                         off, model_free[off], dat_r);
            end
        end else if (int'(adr) == `SW_REG_CTRL) begin
            if (dat_r != ctrl_exp) begin
                errors++;
                $display("[FAIL] dat_r (ctrl) exp 0x%h got 0x%h", ctrl_exp, dat_r);
            end
        end else if (int'(adr) == `SW_REG_RESULT && dat_r[31] && dat_r[4:0] != last_blk) begin
            errors++;
            $display("[FAIL] dat_r (result block) exp 0x%h got 0x%h", last_blk, dat_r[4:0]);
        end
    endtask

    // ------------------------------
    // Judge each allocation on the commit path.
    task automatic check_commit();
        logic [31:0]               elig;
        sw_alloc_pkg::pkt_amount_t best;
        sw_alloc_pkg::sram_idx_t   blk;
        blk = commit.sram;
        if (commit.dest != pend.dest || commit.length != pend.length) begin
            errors++;
            $display("[FAIL] commit dest/length exp 0x%h/0x%h got 0x%h/0x%h",
                     pend.dest, pend.length, commit.dest, commit.length);
        end
        if (pend_sticky) begin
            sticky_hits++;
            if (since_ack != 2) begin
                errors++;
                $display("Sticky match took %0d cycles from ack to commit, not 2.", since_ack);
            end
            if (blk != prev_blk) begin
                errors++;
                $display("[FAIL] commit.sram exp 0x%h got 0x%h", prev_blk, blk);
            end
            prev_free -= sw_alloc_pkg::free_space_t'(pend.length);
        end else begin
            elig = eligible_blocks(mode, pend, best);
            if (since_ack <= int'(thr)) begin
                errors++;
                $display("Match ended %0d cycles after ack, before threshold %0d.",
                         since_ack, thr);
            end
            if (!elig[blk]) begin
                errors++;
                $display("[FAIL] commit.sram 0x%h outside legal set 0x%h", blk, elig);
            end else if (scan_cycle(mode) <= int'(thr) && model_cnt[blk][pend.dest] != best) begin
                errors++;                              // Full cycle seen, must be the max.
                $display("[FAIL] packet_amount exp 0x%h got 0x%h",
                         best, model_cnt[blk][pend.dest]);
            end
            prev_valid = 1'b1;
            prev_dest  = pend.dest;
            prev_blk   = blk;
            prev_free  = model_free[blk] - sw_alloc_pkg::free_space_t'(pend.length);
        end
        model_free[blk]           -= sw_alloc_pkg::free_space_t'(pend.length);
        model_cnt[blk][pend.dest] += 9'd1;
        last_blk = blk;
        commits++;
    endtask

    // Sampled at the falling edge, between register updates.
    always @(negedge clk) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            since_ack++;
            if (cyc && stb && ack) begin            // Bus first, a read shows the old state.
                if (we) track_write();
                else    check_read();
            end
            if (commit.valid) check_commit();
        end
    end

endmodule

// File: sim/tb_sw_alloc.sv
`timescale 1ns/1ps
`include "sw_alloc_defines.svh"

module tb_sw_alloc;

    localparam int PORT_IDX = 3;
    localparam int N_REQ    = 22;               // Requests over all phases.

    logic                       clk;
    logic                       rst_n;
    logic                       cyc;
    logic                       stb;
    logic                       we;
    logic [`SW_WB_ADR_W-1:0]    adr;
    logic [31:0]                dat_w;
    logic [31:0]                dat_r;
    logic                       ack;
    logic [31:0]                rng;            // Xorshift state.
    int                         n_req = 0;
    int                         tb_errors = 0;
    sw_alloc_pkg::sram_update_t dut_commit;

    sw_alloc_top #(.PORT_IDX(PORT_IDX)) u_sw_alloc_top (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
    );

    assign dut_commit = u_sw_alloc_top.commit;  // Allocation as the table gets it.

    alloc_checker #(.PORT_IDX(PORT_IDX)) u_alloc_checker (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .commit(dut_commit)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;                      // 100 ns period.

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] req_word(input sw_alloc_pkg::port_idx_t dest,
                                             input sw_alloc_pkg::pkt_len_t len);
        return {7'd0, len, 12'd0, dest};        // Length 24:16, dest 3:0.
    endfunction

    // ------------------------------
    // Wishbone host tasks.
    task automatic bus_write(input int a, input logic [31:0] d);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= `SW_WB_ADR_W'(a);
        dat_w <= d;
        @(negedge clk);
        while (!ack) @(negedge clk);            // REQ may stall here.
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic bus_read(input int a, output logic [31:0] d);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= `SW_WB_ADR_W'(a);
        @(negedge clk);
        while (!ack) @(negedge clk);
        d = dat_r;                              // Valid in the ack cycle.
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    task automatic set_ctrl(input logic [1:0] mode, input logic [4:0] thr, input logic visc);
        bus_write(`SW_REG_CTRL, {15'd0, visc, 3'd0, thr, 6'd0, mode});
    endtask

    task automatic wait_result(output sw_alloc_pkg::sram_idx_t blk);
        logic [31:0] d;
        d = '0;
        while (!d[31]) bus_read(`SW_REG_RESULT, d);    // Poll until valid.
        blk = d[4:0];
    endtask

    task automatic post_request(input sw_alloc_pkg::port_idx_t dest,
                                input sw_alloc_pkg::pkt_len_t len,
                                output sw_alloc_pkg::sram_idx_t blk);
        logic [31:0] d;
        bus_write(`SW_REG_REQ, req_word(dest, len));
        n_req++;
        wait_result(blk);
        bus_read(`SW_REG_FREE_BASE + int'(blk), d);   // Checker compares the space.
    endtask

    task automatic random_request(input logic [3:0] dest_mask,
                                  output sw_alloc_pkg::sram_idx_t blk);
        rng = xorshift32(rng);
        post_request(rng[3:0] & dest_mask, sw_alloc_pkg::pkt_len_t'(rng[21:16]) + 9'd1, blk);
    endtask

    // ------------------------------
    // Watchdog.
    initial begin
        repeat (N_REQ * 60 + 2000) @(posedge clk);
        $display("Timeout after %0d cycles, a bus cycle or match never ended.",
                 N_REQ * 60 + 2000);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        sw_alloc_pkg::sram_idx_t blk;
        sw_alloc_pkg::sram_idx_t blk_first;
        logic [31:0]             rd_data;
        rng   = 32'd54538;
        rst_n = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        set_ctrl(2'd0, 5'd0, 1'b0);              // Own pair, first fit.
        repeat (6) random_request(4'hf, blk);
        set_ctrl(2'd1, 5'd31, 1'b0);             // Full 17-block cycle, few dests.
        repeat (8) random_request(4'h3, blk);
        set_ctrl(2'd0, 5'd0, 1'b1);              // Sticky on.
        bus_read(`SW_REG_CTRL, rd_data);         // Checker compares the fields.
        post_request(4'd9, 9'd40, blk);
        post_request(4'd9, 9'd30, blk);          // Fits the remembered space.

        set_ctrl(2'd2, 5'd10, 1'b0);
        bus_write(`SW_REG_REQ, req_word(4'd2, 9'd20));
        bus_write(`SW_REG_REQ, req_word(4'd5, 9'd25));   // Lands during the first match.
        n_req += 2;
        wait_result(blk_first);                  // First result was never read.
        wait_result(blk);

        bus_write(`SW_REG_RELEASE, {7'd0, 9'd25, 4'd0, 4'd5, 3'd0, blk});
        bus_read(`SW_REG_FREE_BASE + int'(blk), rd_data);
        rng = xorshift32(rng);
        bus_write(`SW_REG_MASK, rng | 32'h1);    // Keep at least one block.
        set_ctrl(2'd3, 5'd31, 1'b0);
        repeat (4) random_request(4'h7, blk);

        if (u_alloc_checker.commits != n_req) begin
            tb_errors++;
            $display("[FAIL] result_count exp 0x%h got 0x%h", n_req, u_alloc_checker.commits);
        end
        if (u_alloc_checker.sticky_hits == 0) begin
            tb_errors++;
            $display("No request took the sticky path.");
        end
        $display("Errors: checker %0d, testbench %0d; %0d results for %0d requests",
                 u_alloc_checker.errors, tb_errors, u_alloc_checker.commits, n_req);
        if (u_alloc_checker.errors + tb_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+design
design/sw_alloc_pkg.sv
design/wb_req_intake.sv
design/port_wr_sram_matcher.sv
design/sram_status_table.sv
design/alloc_result_readback.sv
design/sw_alloc_top.sv
sim/alloc_checker.sv
sim/tb_sw_alloc.sv

// File: Makefile
TOP  := tb_sw_alloc
SRCS := $(filter-out +%,$(shell cat compile.f)) $(wildcard design/*.svh)

.PHONY: run clean

# Rebuilt only when the file list or a source changes.
obj_dir/V$(TOP): compile.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f compile.f

# Fails unless the pass line shows up in the simulator output.
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir
